/* alien_consts.svh */
// ==========================================================================
// Invader row constants
// Screen margins, sprite geometry, march steps and motion period
// ==========================================================================

`ifndef ALIEN_CONSTS_SVH
`define ALIEN_CONSTS_SVH

// Sprite bitmap size in pixels
`define ALIEN_ROWS 16
`define ALIEN_COLS 22

// Five sprites, 22 wide plus an 8 column gap
`define ALIEN_PITCH 30
`define ALIEN_SLOTS 5

// March step sizes
`define STEP_COLS 12
`define DROP_ROWS 24

// Column margins that trigger a drop and turn
`define LEFT_LIMIT 21
`define RIGHT_LIMIT 500

// Formation origin after reset
`define START_ROW 46
`define START_COL 245

// Row beyond which the formation has landed
`define INVADE_ROW 380

// About half a second at 31.5 MHz
`define MOTION_TICKS_DEFAULT 16000000

`endif

/* alien_formation_motion.sv */
// ==========================================================================
// Invader formation march
// Steps sideways once per period, drops and turns at the screen margins
// ==========================================================================

`timescale 1ns/1ps

`include "alien_consts.svh"

module alien_formation_motion
#(
    parameter int MOTION_TICKS = `MOTION_TICKS_DEFAULT
)
(
    input  logic               clk,
    input  logic               rst_n,
    output alien_pkg::coord_t  origin_row,
    output alien_pkg::coord_t  origin_col,
    output logic               invaded
);

    import alien_pkg::*;

    localparam int CNT_W = (MOTION_TICKS > 1) ? $clog2(MOTION_TICKS) : 1;

    localparam coord_t STEP  = coord_t'(`STEP_COLS);
    localparam coord_t DROP  = coord_t'(`DROP_ROWS);
    localparam coord_t LEFT  = coord_t'(`LEFT_LIMIT);
    localparam coord_t RIGHT = coord_t'(`RIGHT_LIMIT);

    logic [CNT_W-1:0] tick_cnt;
    logic             wrap;
    move_dir_t        dir;
    move_dir_t        dir_next;
    coord_t           row_next;
    coord_t           col_next;

    // Period counter, wraps after MOTION_TICKS cycles
    assign wrap = (tick_cnt == CNT_W'(MOTION_TICKS - 1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            tick_cnt <= '0;
        else if (wrap)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + CNT_W'(1);
    end

    // Next origin and direction
    always_comb
    begin
        row_next = origin_row;
        col_next = origin_col;
        dir_next = dir;
        case (dir)
            DIR_LEFT:
            begin
                if (origin_col < LEFT)
                begin
                    row_next = origin_row + DROP;
                    dir_next = DIR_RIGHT;
                end
                else
                    col_next = origin_col - STEP;
            end
            default:
            begin
                if (origin_col > RIGHT)
                begin
                    row_next = origin_row + DROP;
                    dir_next = DIR_LEFT;
                end
                else
                    col_next = origin_col + STEP;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            origin_row <= coord_t'(`START_ROW);
            origin_col <= coord_t'(`START_COL);
            dir        <= DIR_RIGHT;
        end
        else if (wrap)
        begin
            origin_row <= row_next;
            origin_col <= col_next;
            dir        <= dir_next;
        end
    end

    // Sticky once the row has come down far enough
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            invaded <= 1'b0;
        else if (origin_row > coord_t'(`INVADE_ROW))
            invaded <= 1'b1;
    end

    a_dir_on_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        !wrap |=> $stable(dir));

    a_row_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> (origin_row >= $past(origin_row)));

endmodule

/* alien_pkg.sv */
// ==========================================================================
// Invader row types
// Coordinates, colour, slot mask and march direction
// ==========================================================================

`include "alien_consts.svh"

package alien_pkg;

    // Screen row or column
    typedef logic [11:0] coord_t;

    // Lit pixels are all ones, dark pixels zero
    typedef logic [3:0] pixel_t;

    // Bit k set when the pixel is inside alien k's box
    typedef logic [`ALIEN_SLOTS-1:0] slot_mask_t;

    // March state of the formation
    typedef enum logic
    {
        DIR_RIGHT = 1'b0,
        DIR_LEFT  = 1'b1
    } move_dir_t;

endpackage

/* alien_row_renderer.sv */
// ==========================================================================
// Invader row renderer
// Box test against five slots, one registered stage to colour and mask
// ==========================================================================

`timescale 1ns/1ps

`include "alien_consts.svh"

module alien_row_renderer
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  alien_pkg::coord_t      pixel_row,
    input  alien_pkg::coord_t      pixel_column,
    input  alien_pkg::coord_t      origin_row,
    input  alien_pkg::coord_t      origin_col,
    output alien_pkg::pixel_t      alien_pixel,
    output alien_pkg::slot_mask_t  slot_active
);

    import alien_pkg::*;

    // Boxes are open intervals around the sprite
    localparam coord_t ROW_SPAN = coord_t'(`ALIEN_ROWS + 1);
    localparam coord_t COL_SPAN = coord_t'(`ALIEN_COLS + 1);

    coord_t     row_off;
    logic       row_in;
    slot_mask_t hit;
    logic [4:0] slot_col [`ALIEN_SLOTS];
    logic [4:0] local_row;
    logic [4:0] local_col;
    logic       lit;

    assign row_in    = (origin_row < pixel_row) && (pixel_row < origin_row + ROW_SPAN);
    assign row_off   = pixel_row - origin_row - coord_t'(1);
    assign local_row = row_off[4:0];

    for (genvar k = 0; k < `ALIEN_SLOTS; k++)
    begin : g_slot
        coord_t col_lo;
        coord_t col_off;

        assign col_lo      = origin_col + coord_t'(k * `ALIEN_PITCH);
        assign col_off     = pixel_column - col_lo - coord_t'(1);
        assign slot_col[k] = col_off[4:0];
        assign hit[k]      = row_in && (col_lo < pixel_column)
                          && (pixel_column < col_lo + COL_SPAN);
    end

    // Slots never overlap, so at most one column is picked
    always_comb
    begin
        local_col = '0;
        for (int k = 0; k < `ALIEN_SLOTS; k++)
        begin
            if (hit[k])
                local_col = slot_col[k];
        end
    end

    alien_sprite_rom i_rom
    (
        .local_row (local_row),
        .local_col (local_col),
        .lit       (lit)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            slot_active <= '0;
            alien_pixel <= '0;
        end
        else
        begin
            slot_active <= hit;
            alien_pixel <= ((|hit) && lit) ? '1 : '0;
        end
    end

    // Pitch wider than sprite keeps the boxes disjoint
    a_one_slot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(slot_active));

endmodule

/* alien_row_top.sv */
// ==========================================================================
// Invader B row top level
// Formation march feeding the registered row renderer
// ==========================================================================

`timescale 1ns/1ps

`include "alien_consts.svh"

module alien_row_top
#(
    parameter int MOTION_TICKS = `MOTION_TICKS_DEFAULT
)
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  alien_pkg::coord_t      pixel_row,
    input  alien_pkg::coord_t      pixel_column,
    output alien_pkg::pixel_t      alien_pixel,
    output alien_pkg::slot_mask_t  slot_active,
    output logic                   invaded
);

    import alien_pkg::*;

    // Current formation origin
    coord_t origin_row;
    coord_t origin_col;

    alien_formation_motion #(
        .MOTION_TICKS (MOTION_TICKS)
    ) i_motion (
        .clk        (clk),
        .rst_n      (rst_n),
        .origin_row (origin_row),
        .origin_col (origin_col),
        .invaded    (invaded)
    );

    alien_row_renderer i_renderer
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .origin_row   (origin_row),
        .origin_col   (origin_col),
        .alien_pixel  (alien_pixel),
        .slot_active  (slot_active)
    );

endmodule

/* alien_sprite_rom.sv */
// ==========================================================================
// Invader B sprite bitmap
// Decodes a local row and column into lit or dark, 16 rows by 22 columns
// ==========================================================================

`timescale 1ns/1ps

`include "alien_consts.svh"

module alien_sprite_rom
(
    input  logic [4:0] local_row,
    input  logic [4:0] local_col,
    output logic       lit
);

    localparam logic [4:0] ROW_END = 5'(`ALIEN_ROWS);
    localparam logic [4:0] COL_END = 5'(`ALIEN_COLS);

    logic [4:0] c;

    assign c = local_col;

    // Bitmap is built from row pairs
    always_comb
    begin
        lit = 1'b0;
        if ((local_row < ROW_END) && (c < COL_END))
        begin
            case (local_row[3:1])
                // Antenna tips
                3'd0: lit = (c == 5'd4) || (c == 5'd5) || (c == 5'd16) || (c == 5'd17);
                // Antenna stems
                3'd1: lit = (c == 5'd6) || (c == 5'd7) || (c == 5'd14) || (c == 5'd15);
                // Top of head
                3'd2: lit = (c >= 5'd4) && (c <= 5'd17);
                // Head with the two eye holes
                3'd3:
                begin
                    lit = ((c >= 5'd2) && (c <= 5'd5))
                       || ((c >= 5'd8) && (c <= 5'd13))
                       || ((c >= 5'd16) && (c <= 5'd19));
                end
                // Full width body
                3'd4: lit = 1'b1;
                // Legs, four rows
                3'd5, 3'd6:
                begin
                    lit = (c == 5'd0) || (c == 5'd1) || (c == 5'd4) || (c == 5'd5)
                       || (c == 5'd16) || (c == 5'd17) || (c == 5'd20) || (c == 5'd21);
                end
                // Feet, split in the middle
                3'd7: lit = (c >= 5'd6) && (c <= 5'd15) && (c != 5'd10) && (c != 5'd11);
                default: lit = 1'b0;
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the invader row testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_alien_row -o sim_alien_row

./obj_dir/sim_alien_row | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb_alien_row.sv */
// ==========================================================================
// Invader B row testbench
// Directed tests of bitmap, box test and march against a reference model
// ==========================================================================

`timescale 1ns/1ps

`include "alien_consts.svh"

module tb_alien_row;

    import alien_pkg::*;

    localparam int TICKS = 8;

    // Watchdog budget from the march length plus the bitmap scan
    localparam int DROPS_NEEDED = (`INVADE_ROW - `START_ROW) / `DROP_ROWS + 1;
    localparam int SWEEP_STEPS  = (`RIGHT_LIMIT - `LEFT_LIMIT) / `STEP_COLS + 2;
    localparam int SCAN_PERIODS = (`ALIEN_ROWS * `ALIEN_COLS + 200) / TICKS;
    localparam int RUN_PERIODS  = DROPS_NEEDED * (SWEEP_STEPS + 1) + SWEEP_STEPS + SCAN_PERIODS;

    logic       clk;
    logic       rst_n;
    coord_t     pixel_row;
    coord_t     pixel_column;
    pixel_t     alien_pixel;
    slot_mask_t slot_active;
    logic       invaded;

    int          errors = 0;
    int          checks = 0;
    int unsigned lcg_state = 32'd7;

    // Reference model of the formation origin
    int        m_row;
    int        m_col;
    int        m_cnt;
    int        m_steps;
    move_dir_t m_dir;

    alien_row_top #(
        .MOTION_TICKS (TICKS)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .alien_pixel  (alien_pixel),
        .slot_active  (slot_active),
        .invaded      (invaded)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // March rules, one step per period
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            m_cnt   <= 0;
            m_steps <= 0;
            m_row   <= `START_ROW;
            m_col   <= `START_COL;
            m_dir   <= DIR_RIGHT;
        end
        else if (m_cnt == TICKS - 1)
        begin
            m_cnt   <= 0;
            m_steps <= m_steps + 1;
            if (m_dir == DIR_LEFT && m_col < `LEFT_LIMIT)
            begin
                m_row <= m_row + `DROP_ROWS;
                m_dir <= DIR_RIGHT;
            end
            else if (m_dir == DIR_LEFT)
                m_col <= m_col - `STEP_COLS;
            else if (m_col > `RIGHT_LIMIT)
            begin
                m_row <= m_row + `DROP_ROWS;
                m_dir <= DIR_LEFT;
            end
            else
                m_col <= m_col + `STEP_COLS;
        end
        else
            m_cnt <= m_cnt + 1;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // Invader B bitmap, one string per row pair, column 0 first
    function automatic string sprite_row(input int pair);
        case (pair)
            0: return "....##..........##....";
            1: return "......##......##......";
            2: return "....##############....";
            3: return "..####..######..####..";
            4: return "######################";
            5: return "##..##..........##..##";
            6: return "##..##..........##..##";
            default: return "......####..####......";
        endcase
    endfunction

    function automatic bit in_box(input int row, input int col, input int k);
        int c0;
        c0 = m_col + k * `ALIEN_PITCH;
        return (m_row < row) && (row < m_row + `ALIEN_ROWS + 1)
            && (c0 < col) && (col < c0 + `ALIEN_COLS + 1);
    endfunction

    function automatic slot_mask_t model_mask(input int row, input int col);
        slot_mask_t m;
        m = '0;
        for (int k = 0; k < `ALIEN_SLOTS; k++)
            if (in_box(row, col, k))
                m[k] = 1'b1;
        return m;
    endfunction

    function automatic pixel_t model_pixel(input int row, input int col);
        int    lr;
        int    lc;
        string s;
        for (int k = 0; k < `ALIEN_SLOTS; k++)
        begin
            if (in_box(row, col, k))
            begin
                lr = row - m_row - 1;
                lc = col - m_col - k * `ALIEN_PITCH - 1;
                s  = sprite_row(lr / 2);
                if (s.getc(lc) == "#")
                    return 4'hf;
            end
        end
        return 4'h0;
    endfunction

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // Called on a falling edge, result checked one cycle later
    task automatic probe(input int row, input int col);
        slot_mask_t exp_mask;
        pixel_t     exp_pix;
        exp_mask     = model_mask(row, col);
        exp_pix      = model_pixel(row, col);
        pixel_row    = coord_t'(row);
        pixel_column = coord_t'(col);
        @(negedge clk);
        check_pixel("alien_pixel", alien_pixel, exp_pix);
        check_mask("slot_active", slot_active, exp_mask);
    endtask

    task automatic wait_step();
        int s;
        s = m_steps;
        while (m_steps == s)
            @(negedge clk);
    endtask

    task automatic report(input string name, input int err_before);
        $display("%-10s done, %0d errors", name, errors - err_before);
    endtask

    task automatic test_after_reset();
        int e;
        e = errors;
        check_flag("invaded", invaded, 1'b0);
        check_pixel("alien_pixel", alien_pixel, 4'h0);
        check_mask("slot_active", slot_active, 5'h00);
        probe(m_row + 9, m_col + 6);
        report("reset", e);
    endtask

    task automatic test_bitmap();
        int e;
        e = errors;
        for (int r = 0; r < `ALIEN_ROWS; r++)
            for (int c = 0; c < `ALIEN_COLS; c++)
                probe(m_row + 1 + r, m_col + 2 * `ALIEN_PITCH + 1 + c);
        report("bitmap", e);
    endtask

    task automatic test_gaps();
        int e;
        int r;
        int c;
        e = errors;
        for (int k = 0; k < `ALIEN_SLOTS - 1; k++)
            for (int g = `ALIEN_COLS + 1; g <= `ALIEN_PITCH; g++)
                probe(m_row + 5, m_col + k * `ALIEN_PITCH + g);
        probe(m_row, m_col + 5);
        probe(m_row + 5, m_col);
        probe(m_row + 5, m_col - 1);
        repeat (40)
        begin
            do
            begin
                r = int'(lcg_next() % 32'd480);
                c = int'(lcg_next() % 32'd640);
            end while (model_mask(r, c) != '0);
            probe(r, c);
        end
        report("gaps", e);
    endtask

    task automatic test_march();
        int e;
        e = errors;
        repeat (10)
        begin
            wait_step();
            probe(m_row + 1, m_col + 1);
            probe(m_row + 1, m_col);
        end
        report("march", e);
    endtask

    task automatic test_edge_turn();
        int        e;
        bit        seen_right;
        bit        seen_left;
        move_dir_t prev;
        e          = errors;
        seen_right = 1'b0;
        seen_left  = 1'b0;
        while (!(seen_right && seen_left))
        begin
            prev = m_dir;
            wait_step();
            if (prev == DIR_RIGHT && m_dir == DIR_LEFT)
                seen_right = 1'b1;
            if (prev == DIR_LEFT && m_dir == DIR_RIGHT)
                seen_left = 1'b1;
            probe(m_row + 1, m_col + 1);
            probe(m_row, m_col + 1);
        end
        report("edge_turn", e);
    endtask

    task automatic test_invasion();
        int e;
        e = errors;
        while (m_row <= `INVADE_ROW)
        begin
            wait_step();
            check_flag("invaded", invaded, 1'b0);
        end
        // Flag follows one cycle after the final drop
        @(negedge clk);
        check_flag("invaded", invaded, 1'b1);
        report("invasion", e);
    endtask

    initial
    begin
        #(RUN_PERIODS * TICKS * 20 * 2);
        $display("Watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        rst_n        = 1'b0;
        pixel_row    = '0;
        pixel_column = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_after_reset();
        test_bitmap();
        test_gaps();
        test_march();
        test_edge_turn();
        test_invasion();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
alien_pkg.sv
alien_sprite_rom.sv
alien_row_renderer.sv
alien_formation_motion.sv
alien_row_top.sv
tb_alien_row.sv
